//--- Makefile
# Verilator build and run of the miss unit testbench.
# Every variable can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_miss_unit
OBJ_DIR   ?= obj_dir
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) miss_defines.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes.
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status of the simulator is the test result.
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- miss_alloc_ctrl.sv
`timescale 1ns/1ps
`include "miss_defines.svh"

module miss_alloc_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  miss_pkg::miss_req_t req,
    input  logic                hit,
    input  logic                full,
    output logic                alloc,
    output logic                merge,
    output logic                stall,
    output logic                mem_req_valid,
    output logic [`PADDR_W-1:0] mem_req_paddr
);

    // full is the pre-fill occupancy, so a same-cycle fill does not make room.
    assign merge = req_valid & hit;
    assign alloc = req_valid & ~hit & ~full;
    assign stall = req_valid & ~hit & full;

    // only a fresh allocation goes to memory; merges ride on the earlier fetch.
    always_ff @(posedge clk) begin
        if (rst) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= alloc;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            mem_req_paddr <= req.paddr;
        end
    end

endmodule

//--- miss_defines.svh
`ifndef MISS_DEFINES_SVH
`define MISS_DEFINES_SVH

// number of outstanding misses the MSHR can track.
`define MSHR_DEPTH 8

// physical line address width.
`define PADDR_W 15

// load/store queue slots, one bit each in the slot mask.
`define QSLOTS 8

`endif

//--- miss_pkg.sv
`include "miss_defines.svh"

package miss_pkg;

    // one miss from the load/store queue.
    typedef struct packed {
        logic [`PADDR_W-1:0] paddr;
        logic [`QSLOTS-1:0]  qentry;  // one-hot slot.
        logic                rdsw;    // 1 for a read.
    } miss_req_t;

    // one MSHR entry; wake is {read, write}.
    typedef struct packed {
        logic                valid;
        logic [`PADDR_W-1:0] paddr;
        logic [`QSLOTS-1:0]  qentries;
        logic [1:0]          wake;
    } mshr_entry_t;

    // released on a fill.
    typedef struct packed {
        logic [`QSLOTS-1:0] qentries;
        logic [1:0]         wake;
    } wake_t;

endpackage

//--- miss_unit.sv
`timescale 1ns/1ps
`include "miss_defines.svh"

module miss_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  miss_pkg::miss_req_t req,
    input  logic                fill,
    output logic                req_stall,
    output logic                req_hit,
    output logic                mem_req_valid,
    output logic [`PADDR_W-1:0] mem_req_paddr,
    output logic                wake_valid,
    output miss_pkg::wake_t     wake
);

    logic hit;
    logic full;
    logic alloc;
    logic merge;

    miss_alloc_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .hit           (hit),
        .full          (full),
        .alloc         (alloc),
        .merge         (merge),
        .stall         (req_stall),
        .mem_req_valid (mem_req_valid),
        .mem_req_paddr (mem_req_paddr)
    );

    mshr mshr_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .alloc      (alloc),
        .merge      (merge),
        .fill       (fill),
        .hit        (hit),
        .full       (full),
        .wake_valid (wake_valid),
        .wake       (wake)
    );

    assign req_hit = merge;  // hit only counts with a valid request.

endmodule

//--- mshr.sv
`timescale 1ns/1ps
`include "miss_defines.svh"

module mshr (
    input  logic                clk,
    input  logic                rst,
    input  miss_pkg::miss_req_t req,
    input  logic                alloc,
    input  logic                merge,
    input  logic                fill,
    output logic                hit,
    output logic                full,
    output logic                wake_valid,
    output miss_pkg::wake_t     wake
);

    import miss_pkg::*;

    localparam int IDX_W = $clog2(`MSHR_DEPTH);

    mshr_entry_t            entries [`MSHR_DEPTH];
    mshr_entry_t            new_entry;
    logic [IDX_W-1:0]       head_idx;
    logic                   empty;
    logic                   pop;
    logic [`MSHR_DEPTH-1:0] match_vec;
    logic [`MSHR_DEPTH-1:0] merge_vec;

    // the head leaves on a fill, so it must not take a merge.
    always_comb begin
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            match_vec[i] = entries[i].valid
                        && (entries[i].paddr == req.paddr)
                        && !(fill && (head_idx == IDX_W'(i)));
        end
    end

    assign hit       = |match_vec;
    assign merge_vec = match_vec & {`MSHR_DEPTH{merge}};

    always_comb begin
        new_entry.valid    = 1'b1;
        new_entry.paddr    = req.paddr;
        new_entry.qentries = req.qentry;
        new_entry.wake     = {req.rdsw, ~req.rdsw};  // read in bit 1, write in bit 0.
    end

    assign pop = fill & ~empty;  // a fill with nothing outstanding is dropped.

    assign wake_valid    = pop;
    assign wake.qentries = entries[head_idx].qentries;
    assign wake.wake     = entries[head_idx].wake;

    mshr_queue queue_i (
        .clk         (clk),
        .rst         (rst),
        .alloc       (alloc),
        .alloc_entry (new_entry),
        .pop         (pop),
        .merge_vec   (merge_vec),
        .merge_mask  (req.qentry),
        .entries     (entries),
        .head_idx    (head_idx),
        .full        (full),
        .empty       (empty)
    );

endmodule

//--- mshr_queue.sv
`timescale 1ns/1ps
`include "miss_defines.svh"

module mshr_queue (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc,
    input  miss_pkg::mshr_entry_t       alloc_entry,
    input  logic                        pop,
    input  logic [`MSHR_DEPTH-1:0]      merge_vec,
    input  logic [`QSLOTS-1:0]          merge_mask,
    output miss_pkg::mshr_entry_t       entries [`MSHR_DEPTH],
    output logic [$clog2(`MSHR_DEPTH)-1:0] head_idx,
    output logic                        full,
    output logic                        empty
);

    localparam int IDX_W = $clog2(`MSHR_DEPTH);

    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       tail;
    logic [IDX_W:0]         count;
    logic [`MSHR_DEPTH-1:0] valid_q;

    logic [`PADDR_W-1:0] paddr_q    [`MSHR_DEPTH];
    logic [`QSLOTS-1:0]  qentries_q [`MSHR_DEPTH];
    logic [1:0]          wake_q     [`MSHR_DEPTH];

    // pointers, occupancy and valid bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            valid_q <= '0;
        end else begin
            if (pop) begin
                valid_q[head] <= 1'b0;
                head <= (head == IDX_W'(`MSHR_DEPTH - 1)) ? '0 : head + 1'b1;
            end
            if (alloc) begin
                valid_q[tail] <= alloc_entry.valid;
                tail <= (tail == IDX_W'(`MSHR_DEPTH - 1)) ? '0 : tail + 1'b1;
            end
            case ({alloc, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            if (merge_vec[i]) begin
                qentries_q[i] <= qentries_q[i] | merge_mask;  // merge never hits the tail being written.
            end
        end
        if (alloc) begin
            paddr_q[tail]    <= alloc_entry.paddr;
            qentries_q[tail] <= alloc_entry.qentries;
            wake_q[tail]     <= alloc_entry.wake;
        end
    end

    always_comb begin
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            entries[i].valid    = valid_q[i];
            entries[i].paddr    = paddr_q[i];
            entries[i].qentries = qentries_q[i];
            entries[i].wake     = wake_q[i];
        end
    end

    assign head_idx = head;
    assign full     = (count == (IDX_W + 1)'(`MSHR_DEPTH));
    assign empty    = (count == '0);

endmodule

//--- src.f
+incdir+.
miss_pkg.sv
mshr_queue.sv
mshr.sv
miss_alloc_ctrl.sv
miss_unit.sv
tb_miss_unit.sv

//--- tb_miss_unit.sv
`timescale 1ns/1ps
`include "miss_defines.svh"

module tb_miss_unit;

    import miss_pkg::*;

    localparam int RANDOM_CYCLES = 1200;
    localparam int POOL_SIZE     = 6;
    localparam int MAX_CYCLES    = 2000;  // about 1,500 cycles of phases and drains, plus margin.

    logic                clk;
    logic                rst;
    logic                req_valid;
    miss_req_t           req;
    logic                fill;
    logic                req_stall;
    logic                req_hit;
    logic                mem_req_valid;
    logic [`PADDR_W-1:0] mem_req_paddr;
    logic                wake_valid;
    wake_t               wake;

    mshr_entry_t         model_q [$];     // oldest entry first.
    logic [`PADDR_W-1:0] mem_expect [$];  // addresses due on mem_req_paddr.
    logic [`PADDR_W-1:0] addr_pool [POOL_SIZE];
    logic [31:0]         rng;
    string               test_name;
    int                  cycle_count;
    int                  errors;

    miss_unit dut_i (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .fill          (fill),
        .req_stall     (req_stall),
        .req_hit       (req_hit),
        .mem_req_valid (mem_req_valid),
        .mem_req_paddr (mem_req_paddr),
        .wake_valid    (wake_valid),
        .wake          (wake)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: run still going after %0d cycles in %s",
                                cycle_count, test_name));
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic miss_req_t make_req(input logic [`PADDR_W-1:0] paddr,
                                           input int slot,
                                           input logic rdsw);
        miss_req_t r;
        r.paddr  = paddr;
        r.qentry = `QSLOTS'(1) << slot;  // one-hot slot.
        r.rdsw   = rdsw;
        return r;
    endfunction

    task automatic abort_run(input string msg);
        errors = errors + 1;
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic expect_eq(input string sig, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors = errors + 1;
            $display("error %s %s: expected %0h, actual %0h", test_name, sig, exp, act);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // one clock cycle: drive, predict from the model, check, then advance the model.
    task automatic drive_cycle(input logic v, input miss_req_t r, input logic f,
                               output logic stalled);
        logic        any_match;
        logic        do_pop;
        logic        exp_full;
        logic        exp_alloc;
        mshr_entry_t e;
        @(posedge clk);
        #2;
        req_valid = v;
        req       = r;
        fill      = f;
        #18;
        do_pop    = f && (model_q.size() != 0);
        exp_full  = (model_q.size() == `MSHR_DEPTH);  // judged before the pop.
        any_match = 1'b0;
        for (int i = 0; i < model_q.size(); i++) begin
            if (!(f && i == 0) && model_q[i].paddr == r.paddr) begin
                any_match = 1'b1;
            end
        end
        exp_alloc = v && !any_match && !exp_full;
        stalled   = v && !any_match && exp_full;

        expect_eq("req_hit", 32'(v && any_match), 32'(req_hit));
        expect_eq("req_stall", 32'(stalled), 32'(req_stall));
        expect_eq("wake_valid", 32'(do_pop), 32'(wake_valid));
        if (do_pop) begin
            e = model_q[0];
            expect_eq("wake.qentries", 32'(e.qentries), 32'(wake.qentries));
            expect_eq("wake.wake", 32'(e.wake), 32'(wake.wake));
        end
        expect_eq("mem_req_valid", 32'(mem_expect.size() != 0), 32'(mem_req_valid));
        if (mem_expect.size() != 0) begin
            expect_eq("mem_req_paddr", 32'(mem_expect[0]), 32'(mem_req_paddr));
            void'(mem_expect.pop_front());
        end

        // the edge merges first, then pops the head, then writes the tail.
        if (v && any_match) begin
            for (int i = 0; i < model_q.size(); i++) begin
                if (!(f && i == 0) && model_q[i].paddr == r.paddr) begin
                    e          = model_q[i];
                    e.qentries = e.qentries | r.qentry;
                    model_q[i] = e;
                end
            end
        end
        if (do_pop) begin
            void'(model_q.pop_front());
        end
        if (exp_alloc) begin
            e.valid    = 1'b1;
            e.paddr    = r.paddr;
            e.qentries = r.qentry;
            e.wake     = r.rdsw ? 2'b10 : 2'b01;
            model_q.push_back(e);
            mem_expect.push_back(r.paddr);
        end
    endtask

    task automatic drain_fills();
        logic stalled;
        while (model_q.size() != 0) begin
            drive_cycle(1'b0, '0, 1'b1, stalled);
        end
        drive_cycle(1'b0, '0, 1'b0, stalled);  // last memory pulse lands here.
    endtask

    initial begin
        logic      stalled;
        logic      accepted;
        logic      held_stall;
        logic      v;
        logic      f;
        miss_req_t r;
        int        idx;
        clk         = 1'b0;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        fill        = 1'b0;
        rng         = 32'hb768;
        cycle_count = 0;
        errors      = 0;
        test_name   = "reset";
        addr_pool[0] = `PADDR_W'('h0a40);
        addr_pool[1] = `PADDR_W'('h0a41);
        addr_pool[2] = `PADDR_W'('h1b00);
        addr_pool[3] = `PADDR_W'('h2c7f);
        addr_pool[4] = `PADDR_W'('h3e15);
        addr_pool[5] = `PADDR_W'('h7fff);

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        expect_eq("wake_valid", 32'(0), 32'(wake_valid));
        expect_eq("mem_req_valid", 32'(0), 32'(mem_req_valid));
        expect_eq("req_stall", 32'(0), 32'(req_stall));
        drive_cycle(1'b0, '0, 1'b1, stalled);  // fill on an empty MSHR.
        drive_cycle(1'b0, '0, 1'b0, stalled);

        test_name = "allocation";
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, make_req(`PADDR_W'('h100 + i), i, i[0]), 1'b0, stalled);
        end

        test_name = "merging";
        drive_cycle(1'b1, make_req(`PADDR_W'('h102), 5, 1'b0), 1'b0, stalled);
        drive_cycle(1'b1, make_req(`PADDR_W'('h102), 6, 1'b1), 1'b0, stalled);
        drive_cycle(1'b1, make_req(`PADDR_W'('h100), 7, 1'b1), 1'b0, stalled);
        drain_fills();

        test_name = "full";
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            drive_cycle(1'b1, make_req(`PADDR_W'('h200 + i), i % `QSLOTS, 1'b1), 1'b0, stalled);
        end
        r          = make_req(`PADDR_W'('h300), 3, 1'b0);
        accepted   = 1'b0;
        held_stall = 1'b0;
        for (int k = 0; k < 8 && !accepted; k++) begin
            drive_cycle(1'b1, r, (k == 3), stalled);  // the fill at k == 3 still stalls.
            if (req_stall) begin
                held_stall = 1'b1;
            end else begin
                accepted = 1'b1;
            end
        end
        assert (held_stall && accepted) else
            abort_run("held request on a full MSHR was not stalled and then accepted");
        drain_fills();

        test_name = "in-order fill";
        drive_cycle(1'b1, make_req(`PADDR_W'('h400), 0, 1'b1), 1'b0, stalled);
        drive_cycle(1'b1, make_req(`PADDR_W'('h401), 1, 1'b0), 1'b0, stalled);
        drive_cycle(1'b1, make_req(`PADDR_W'('h400), 2, 1'b0), 1'b1, stalled);
        drain_fills();

        test_name = "random traffic";
        stalled   = 1'b0;
        v         = 1'b0;
        r         = '0;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            if (!stalled) begin  // a stalled requester holds its request.
                rng = xorshift32(rng);
                idx = int'(rng[15:8]) % POOL_SIZE;
                v   = (rng[1:0] != 2'b00);
                r   = make_req(addr_pool[idx], int'(rng[18:16]), rng[20]);
            end
            rng = xorshift32(rng);
            f   = (rng[2:0] < 3'd3);
            drive_cycle(v, r, f, stalled);
        end
        drain_fills();

        if (errors == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("Test FAILED");
            $fatal(1);
        end
    end

endmodule
